/* build.f */
hdl/sa_pkg.sv
hdl/skew_lane.sv
hdl/skew_bank.sv
hdl/mac_pe.sv
hdl/pe_grid.sv
hdl/mm_sequencer.sv
hdl/systolic_mm_top.sv
tb/systolic_mm_assert.sv
tb/tb_systolic_mm.sv

/* hdl/mac_pe.sv */
`timescale 1ns/1ps

module mac_pe (
  input  logic             clk,
  input  logic             nrst,
  input  logic             clr_acc,
  input  sa_pkg::act_tok_t a_in,
  input  sa_pkg::wgt_tok_t b_in,
  output sa_pkg::act_tok_t a_out,
  output sa_pkg::wgt_tok_t b_out,
  output sa_pkg::acc_t     acc
);

  localparam int prod_w = sa_pkg::act_w + sa_pkg::wgt_w + 1;

  logic signed [sa_pkg::act_w:0] a_ext;
  logic signed [prod_w-1:0]      prod;
  logic                          both_valid;

  assign a_ext      = {1'b0, a_in.data};   // zero-extend so the activation stays positive.
  assign prod       = a_ext * b_in.data;
  assign both_valid = a_in.valid && b_in.valid;

  always_ff @(posedge clk, negedge nrst)
  begin
    if (!nrst)
    begin
      a_out <= '0;
      b_out <= '0;
      acc   <= '0;
    end
    else
    begin
      a_out <= a_in;
      b_out <= b_in;
      if (clr_acc)
      begin
        acc <= '0;                         // a new tile wins over a late product.
      end
      else if (both_valid)
      begin
        acc <= acc + {{(sa_pkg::acc_w - prod_w){prod[prod_w-1]}}, prod};
      end
    end
  end

endmodule

/* hdl/mm_sequencer.sv */
`timescale 1ns/1ps

module mm_sequencer (
  input  logic clk,
  input  logic nrst,
  input  logic start,
  input  logic feed_en,
  output logic feed_ok,
  output logic clr_acc,
  output logic done
);

  logic                           tile_open;
  logic [sa_pkg::feed_cnt_w-1:0]  feed_cnt;
  logic [sa_pkg::drain_cnt_w-1:0] drain_cnt;
  logic                           last_feed;
  logic                           drain_end;

  // a feed in the start cycle belongs to neither tile, so it is dropped.
  assign feed_ok = feed_en && tile_open && !start &&
                   (feed_cnt < sa_pkg::feed_cnt_w'(sa_pkg::grid_n));

  assign last_feed = feed_ok && (feed_cnt == sa_pkg::feed_cnt_w'(sa_pkg::grid_n - 1));
  assign drain_end = (drain_cnt == sa_pkg::drain_cnt_w'(1));
  assign clr_acc   = start;                // the grid clears on the start edge.

  always_ff @(posedge clk, negedge nrst)
  begin
    if (!nrst)
    begin
      tile_open <= 1'b0;
      feed_cnt  <= '0;
      drain_cnt <= '0;
      done      <= 1'b0;
    end
    else
    begin
      done <= drain_end && !start;
      if (start)
      begin
        tile_open <= 1'b1;
        feed_cnt  <= '0;
        drain_cnt <= '0;                   // a restart drops any pending done.
      end
      else
      begin
        if (feed_ok)
        begin
          feed_cnt <= feed_cnt + 1'b1;
        end
        if (last_feed)
        begin
          drain_cnt <= sa_pkg::drain_cnt_w'(sa_pkg::drain_cycles);
        end
        else if (drain_cnt != '0)
        begin
          drain_cnt <= drain_cnt - 1'b1;
        end
        if (drain_end)
        begin
          tile_open <= 1'b0;
        end
      end
    end
  end

endmodule

/* hdl/pe_grid.sv */
`timescale 1ns/1ps

module pe_grid (
  input  logic                 clk,
  input  logic                 nrst,
  input  logic                 clr_acc,
  input  sa_pkg::act_tok_vec_t a_edge,
  input  sa_pkg::wgt_tok_vec_t b_edge,
  output sa_pkg::result_t      acc_all
);

  // one extra column and row catch the outputs at the far edges.
  sa_pkg::act_tok_t a_h [sa_pkg::grid_n][sa_pkg::grid_n+1];
  sa_pkg::wgt_tok_t b_v [sa_pkg::grid_n+1][sa_pkg::grid_n];

  for (genvar i = 0; i < sa_pkg::grid_n; i++)
  begin : g_left
    assign a_h[i][0] = a_edge[i];
  end

  for (genvar j = 0; j < sa_pkg::grid_n; j++)
  begin : g_top
    assign b_v[0][j] = b_edge[j];
  end

  for (genvar i = 0; i < sa_pkg::grid_n; i++)
  begin : g_row
    for (genvar j = 0; j < sa_pkg::grid_n; j++)
    begin : g_col
      mac_pe u_pe (
        .clk     (clk),
        .nrst    (nrst),
        .clr_acc (clr_acc),
        .a_in    (a_h[i][j]),
        .b_in    (b_v[i][j]),
        .a_out   (a_h[i][j+1]),         // to the right neighbour.
        .b_out   (b_v[i+1][j]),         // to the cell below.
        .acc     (acc_all[i][j])
      );
    end
  end

endmodule

/* hdl/sa_pkg.sv */
package sa_pkg;

  localparam int grid_n = 4;
  localparam int act_w = 8;
  localparam int wgt_w = 8;
  localparam int acc_w = 24;

  // the last product reaches cell (n-1,n-1) after 2n-1 edges, plus margin for the result.
  localparam int drain_cycles = 2 * grid_n + 1;

  localparam int feed_cnt_w = $clog2(grid_n + 1);
  localparam int drain_cnt_w = $clog2(drain_cycles + 1);

  typedef logic [act_w-1:0] act_t;          // activations are unsigned.
  typedef logic signed [wgt_w-1:0] wgt_t;   // weights are two's complement.
  typedef logic signed [acc_w-1:0] acc_t;

  typedef struct packed {
    logic valid;
    act_t data;
  } act_tok_t;

  typedef struct packed {
    logic valid;
    wgt_t data;
  } wgt_tok_t;

  // one column of A, element i is A[i][k].
  typedef act_t [grid_n-1:0] act_vec_t;

  // one row of B, element j is B[k][j].
  typedef wgt_t [grid_n-1:0] wgt_vec_t;

  typedef act_tok_t [grid_n-1:0] act_tok_vec_t;
  typedef wgt_tok_t [grid_n-1:0] wgt_tok_vec_t;

  // indexed as result[i][j], row first.
  typedef acc_t [grid_n-1:0][grid_n-1:0] result_t;

endpackage

/* hdl/skew_bank.sv */
`timescale 1ns/1ps

module skew_bank #(
  parameter type tok_t = logic
) (
  input  logic                       clk,
  input  logic                       nrst,
  input  tok_t [sa_pkg::grid_n-1:0]  din,
  output tok_t [sa_pkg::grid_n-1:0]  dout
);

  tok_t [sa_pkg::grid_n-1:0] din_q;

  always_ff @(posedge clk, negedge nrst)
  begin
    if (!nrst)
    begin
      din_q <= '0;
    end
    else
    begin
      din_q <= din;                        // common first stage for all lanes.
    end
  end

  // lane i lags lane 0 by i cycles, giving the diagonal wavefront.
  for (genvar i = 0; i < sa_pkg::grid_n; i++)
  begin : g_lane
    skew_lane #(
      .tok_t (tok_t),
      .depth (i)
    ) u_lane (
      .clk  (clk),
      .nrst (nrst),
      .din  (din_q[i]),
      .dout (dout[i])
    );
  end

endmodule

/* hdl/skew_lane.sv */
`timescale 1ns/1ps

module skew_lane #(
  parameter type tok_t = logic,
  parameter int depth = 1
) (
  input  logic clk,
  input  logic nrst,
  input  tok_t din,
  output tok_t dout
);

  generate
    if (depth == 0)
    begin : g_wire
      assign dout = din;
    end
    else
    begin : g_chain
      tok_t stage [depth];

      always_ff @(posedge clk, negedge nrst)
      begin
        if (!nrst)
        begin
          for (int s = 0; s < depth; s++)
          begin
            stage[s] <= '0;                 // no stale valid after reset.
          end
        end
        else
        begin
          stage[0] <= din;
          for (int s = 1; s < depth; s++)
          begin
            stage[s] <= stage[s-1];
          end
        end
      end

      assign dout = stage[depth-1];
    end
  endgenerate

endmodule

/* hdl/systolic_mm_top.sv */
`timescale 1ns/1ps

module systolic_mm_top (
  input  logic             clk,
  input  logic             nrst,
  input  logic             start,
  input  logic             feed_en,
  input  sa_pkg::act_vec_t a_col,
  input  sa_pkg::wgt_vec_t b_row,
  output logic             done,
  output sa_pkg::result_t  result
);

  logic                 feed_ok;
  logic                 clr_acc;
  sa_pkg::act_tok_vec_t a_tok;
  sa_pkg::wgt_tok_vec_t b_tok;
  sa_pkg::act_tok_vec_t a_edge;
  sa_pkg::wgt_tok_vec_t b_edge;

  mm_sequencer u_seq (
    .clk     (clk),
    .nrst    (nrst),
    .start   (start),
    .feed_en (feed_en),
    .feed_ok (feed_ok),
    .clr_acc (clr_acc),
    .done    (done)
  );

  // the valid bit rides along with every element through the skew.
  for (genvar i = 0; i < sa_pkg::grid_n; i++)
  begin : g_tok
    assign a_tok[i] = '{valid: feed_ok, data: a_col[i]};
    assign b_tok[i] = '{valid: feed_ok, data: b_row[i]};
  end

  skew_bank #(
    .tok_t (sa_pkg::act_tok_t)
  ) u_row_bank (
    .clk  (clk),
    .nrst (nrst),
    .din  (a_tok),
    .dout (a_edge)
  );

  skew_bank #(
    .tok_t (sa_pkg::wgt_tok_t)
  ) u_col_bank (
    .clk  (clk),
    .nrst (nrst),
    .din  (b_tok),
    .dout (b_edge)
  );

  pe_grid u_grid (
    .clk     (clk),
    .nrst    (nrst),
    .clr_acc (clr_acc),
    .a_edge  (a_edge),
    .b_edge  (b_edge),
    .acc_all (result)
  );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the systolic multiplier testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_systolic_mm \
  && ./obj_dir/Vtb_systolic_mm > sim.log 2>&1

grep -qx "TEST OK" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

/* tb/mm_trace.txt */
# each record starts with name gap0 gap1 gap2 gap3 extra (gaps are idle cycles before each feed)
# then four row lines with A[i][0..3] B[i][0..3] C[i][0..3] in decimal
basic 0 0 0 0 0
1 2 3 4          1 0 -1 2        6 0 7 3
5 6 7 8          0 1 2 -1        18 0 15 11
9 10 11 12       3 -2 0 1        30 0 23 19
13 14 15 16      -1 1 1 0        42 0 31 27
gapped 3 0 5 1 2
255 255 0 0      -128 127 1 -1   -32130 31620 1275 -1530
0 1 2 3          2 -3 4 -5       1 61 37 375
200 0 0 100      10 20 30 40     -26300 26200 -700 9800
4 3 2 1          -7 8 -9 100     -493 547 67 161
clear 0 0 0 0 0
1 0 0 0          1 2 3 4         1 2 3 4
0 1 0 0          -1 -2 -3 -4     -1 -2 -3 -4
0 0 1 0          5 6 7 8         5 6 7 8
0 0 0 1          -5 -6 -7 -8     -5 -6 -7 -8
wide 1 2 1 7 3
255 255 255 255  -128 127 0 1    -130560 129540 0 3825
255 0 255 0      -128 127 0 2    -65280 64770 0 1275
0 0 0 0          -128 127 0 4    0 0 0 0
1 2 4 8          -128 127 0 8    -1920 1905 0 85
sparse 0 4 0 0 1
3 0 7 1          2 -1 0 3        -15 -1 36 12
0 9 0 2          1 4 -2 0        9 40 -16 -8
6 5 4 3          -3 0 5 1        5 20 13 10
10 0 0 11        0 2 1 -4        20 12 11 -14

/* tb/systolic_mm_assert.sv */
`timescale 1ns/1ps

module systolic_mm_assert (
  input logic clk,
  input logic nrst,
  input logic feed_en,
  input logic feed_ok,
  input logic done
);

  int fail_cnt = 0;

  done_single_cycle: assert property (@(posedge clk) disable iff (!nrst) done |=> !done)
  else
  begin
    $error("done stayed high for two consecutive cycles");
    fail_cnt++;
  end

  // the sequencer may drop a feed but never invent one.
  feed_ok_needs_feed_en: assert property (@(posedge clk) disable iff (!nrst) feed_ok |-> feed_en)
  else
  begin
    $error("feed_ok was high without feed_en");
    fail_cnt++;
  end

  done_low_in_reset: assert property (@(posedge clk) !nrst |-> !done)
  else
  begin
    $error("done was high while nrst was low");
    fail_cnt++;
  end

endmodule

bind mm_sequencer systolic_mm_assert u_seq_checks (
  .clk     (clk),
  .nrst    (nrst),
  .feed_en (feed_en),
  .feed_ok (feed_ok),
  .done    (done)
);

/* tb/tb_systolic_mm.sv */
`timescale 1ns/1ps

module tb_systolic_mm;

  logic             clk;
  logic             nrst;
  logic             start;
  logic             feed_en;
  sa_pkg::act_vec_t a_col;
  sa_pkg::wgt_vec_t b_row;
  logic             done;
  sa_pkg::result_t  result;

  int              fd;
  logic [8*16-1:0] tile_name;
  int              gaps [sa_pkg::grid_n];
  int              extra;
  int              a_m [sa_pkg::grid_n][sa_pkg::grid_n];
  int              b_m [sa_pkg::grid_n][sa_pkg::grid_n];
  int              c_m [sa_pkg::grid_n][sa_pkg::grid_n];

  systolic_mm_top u_dut (
    .clk     (clk),
    .nrst    (nrst),
    .start   (start),
    .feed_en (feed_en),
    .a_col   (a_col),
    .b_row   (b_row),
    .done    (done),
    .result  (result)
  );

  always #50 clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic drive_idle();
    start   = 1'b0;
    feed_en = 1'b0;
    a_col   = '0;
    b_row   = '0;
  endtask

  task automatic drive_random_feed();
    start   = 1'b0;
    feed_en = 1'b1;
    a_col   = $urandom;
    b_row   = $urandom;
  endtask

  task automatic check_result(input string label);
    sa_pkg::acc_t got_acc;
    int           got;
    for (int i = 0; i < sa_pkg::grid_n; i++)
    begin
      for (int j = 0; j < sa_pkg::grid_n; j++)
      begin
        got_acc = result[i][j];
        got     = got_acc;                 // sign-extends the accumulator.
        assert (got == c_m[i][j])
        else report_failure($sformatf("FAIL %s C[%0d][%0d] expected %0d actual %0d",
                                      label, i, j, c_m[i][j], got));
      end
    end
  endtask

  // C[i][j] is the sum over k of A[i][k] * B[k][j].
  task automatic check_trace_sum();
    int sum;
    for (int i = 0; i < sa_pkg::grid_n; i++)
    begin
      for (int j = 0; j < sa_pkg::grid_n; j++)
      begin
        sum = 0;
        for (int k = 0; k < sa_pkg::grid_n; k++)
        begin
          sum += a_m[i][k] * b_m[k][j];
        end
        assert (sum == c_m[i][j])
        else report_failure($sformatf("trace tile %0s lists C[%0d][%0d] as %0d but %0d is right",
                                      tile_name, i, j, c_m[i][j], sum));
      end
    end
  endtask

  task automatic read_tile(output bit found);
    int code;
    found = 1'b0;
    code  = $fscanf(fd, "%s %d %d %d %d %d", tile_name, gaps[0], gaps[1], gaps[2], gaps[3], extra);
    if (code == 6)
    begin
      found = 1'b1;
      for (int i = 0; i < sa_pkg::grid_n; i++)
      begin
        code = $fscanf(fd, "%d %d %d %d %d %d %d %d %d %d %d %d",
                       a_m[i][0], a_m[i][1], a_m[i][2], a_m[i][3],
                       b_m[i][0], b_m[i][1], b_m[i][2], b_m[i][3],
                       c_m[i][0], c_m[i][1], c_m[i][2], c_m[i][3]);
        assert (code == 12)
        else report_failure("the trace file ends in the middle of a tile record");
      end
    end
  endtask

  task automatic run_tile();
    int lat;
    drive_idle();
    start = 1'b1;                          // clears the grid on the next edge.
    @(negedge clk);
    for (int k = 0; k < sa_pkg::grid_n; k++)
    begin
      for (int g = 0; g < gaps[k]; g++)
      begin
        drive_idle();
        @(negedge clk);
      end
      start   = 1'b0;
      feed_en = 1'b1;
      for (int i = 0; i < sa_pkg::grid_n; i++)
      begin
        a_col[i] = sa_pkg::act_t'(a_m[i][k]);
        b_row[i] = sa_pkg::wgt_t'(b_m[k][i]);
      end
      @(negedge clk);
    end
    // the fourth feed was taken on the last edge, and surplus feeds follow it.
    lat = 0;
    while (!done && lat < 40)
    begin
      if (lat < extra)
      begin
        drive_random_feed();
      end
      else
      begin
        drive_idle();
      end
      @(negedge clk);
      lat++;
    end
    drive_idle();
    assert (done)
    else report_failure($sformatf("tile %0s got no done pulse within 40 cycles", tile_name));
    // done follows the edge that took the fourth feed by nine cycles.
    assert (lat == 9)
    else report_failure($sformatf("FAIL %0s done latency expected %0d actual %0d",
                                  tile_name, 9, lat));
    check_result($sformatf("%0s", tile_name));
  endtask

  initial
  begin
    int              tile_cnt;
    bit              found;
    logic [8*128-1:0] skip_line;
    clk     = 1'b0;
    nrst    = 1'b0;
    start   = 1'b0;
    feed_en = 1'b0;
    a_col   = '0;
    b_row   = '0;
    void'($urandom(17981));
    fd = $fopen("tb/mm_trace.txt", "r");
    assert (fd != 0)
    else report_failure("cannot open tb/mm_trace.txt");
    void'($fgets(skip_line, fd));          // two lines describe the columns.
    void'($fgets(skip_line, fd));

    repeat (4) @(negedge clk);
    nrst = 1'b1;

    // no tile is open yet, so these feeds must be dropped.
    for (int i = 0; i < sa_pkg::grid_n; i++)
    begin
      for (int j = 0; j < sa_pkg::grid_n; j++)
      begin
        c_m[i][j] = 0;
      end
    end
    for (int c = 0; c < 14; c++)
    begin
      if (c < 3)
      begin
        drive_random_feed();
      end
      else
      begin
        drive_idle();
      end
      @(negedge clk);
      assert (!done)
      else report_failure("done pulsed before any tile was started");
      check_result("reset");
    end

    tile_cnt = 0;
    read_tile(found);
    while (found)
    begin
      check_trace_sum();
      run_tile();
      tile_cnt++;
      read_tile(found);
    end
    $fclose(fd);
    assert (tile_cnt >= 2)
    else report_failure("the trace file holds fewer than two tiles");

    // after done the tile is closed and the result holds.
    for (int c = 0; c < 14; c++)
    begin
      if (c < 2)
      begin
        drive_random_feed();
      end
      else
      begin
        drive_idle();
      end
      @(negedge clk);
      assert (!done)
      else report_failure("done pulsed while no tile was open");
    end
    check_result($sformatf("%0s hold", tile_name));

    if (u_dut.u_seq.u_seq_checks.fail_cnt == 0)
    begin
      $display("TEST OK");
      $finish;
    end
    else
    begin
      $display("TEST FAILED");
      $fatal(1, "sequencer assertions failed during the run");
    end
  end

endmodule
